// File: Makefile
SOURCES = mem_bus_pkg.sv lsu_pkg.sv id_fifo.sv load_store_queue.sv lsu_bus_master.sv \
          data_ram.sv lsu_top.sv tb_lsu_top.sv

obj_dir/Vtb_lsu_top: build.f $(SOURCES)
	verilator --binary --timing --top-module tb_lsu_top -f build.f

run: obj_dir/Vtb_lsu_top
	@out=$$(./obj_dir/Vtb_lsu_top 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: build.f
mem_bus_pkg.sv
lsu_pkg.sv
id_fifo.sv
load_store_queue.sv
lsu_bus_master.sv
data_ram.sv
lsu_top.sv
tb_lsu_top.sv

// File: data_ram.sv
// data_ram: wishbone classic slave word memory with byte selects and registered ack

module data_ram
    import mem_bus_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    data_t            mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             access;
    logic             ack_r;
    data_t            rdata_r;

    // contents start cleared
    initial begin
        for (int i = 0; i < RAM_WORDS; i++)
            mem[i] = '0;
    end

    // word address wraps on the array size
    assign idx = IDX_W'(wb_req.adr % RAM_WORDS);

    // first cycle of a request, ack not yet given
    assign access = wb_req.cyc & wb_req.stb & ~ack_r;

    // selected bytes only
    always_ff @(posedge clk) begin
        if (access & wb_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (wb_req.sel[b])
                    mem[idx][b*8 +: 8] <= wb_req.dat[b*8 +: 8];
            end
        end
    end

    // whole word, lands with the ack
    always_ff @(posedge clk) begin
        if (access)
            rdata_r <= mem[idx];
    end

    always_ff @(posedge clk) begin
        if (rst)
            ack_r <= 1'b0;
        else
            ack_r <= access;
    end

    assign wb_rsp.ack = ack_r;
    assign wb_rsp.dat = rdata_r;

endmodule

// File: id_fifo.sv
// id_fifo: circular FIFO with type-parameterized payload, combinational head output

module id_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t data_in,
    input  logic     pop,
    output payload_t data_out,
    output logic     valid,
    output logic     full
);

    // pointer and occupancy widths
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    // payload array, written at the tail
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= data_in;
    end

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // push and pop together leave count alone
            if (push & ~pop)
                count <= count + 1'b1;
            else if (pop & ~push)
                count <= count - 1'b1;
        end
    end

    // head straight from the array
    assign data_out = mem[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));

endmodule

// File: load_store_queue.sv
// load_store_queue: id-indexed request store, oldest-first order, store forwarding wait, lane replication

module load_store_queue
    import mem_bus_pkg::*;
    import lsu_pkg::*;
#(
    parameter int MAX_IDS = 8
) (
    input  logic             clk,
    input  logic             rst,

    // issue
    input  logic             issue_valid,
    input  lsq_request_t     issue,

    // to bus master
    output logic             transaction_ready,
    output lsq_transaction_t transaction,
    input  logic             accepted,
    output logic             empty,

    // writeback stage forwarding
    output logic             fwd_waiting,
    output id_t              fwd_id_needed,
    output logic             fwd_ack,
    input  logic             fwd_done,
    input  data_t            fwd_data,
    output logic             ready_for_forwarded_store
);

    // request storage, one slot per id
    lsq_request_t entries [MAX_IDS];
    lsq_request_t oldest_entry;
    id_t          oldest_id;
    logic         order_valid;
    logic         order_full;
    logic         order_push;

    // forwarding state
    logic         new_forwarded_store;
    logic         waiting_r;
    id_t          needed_id_r;

    // store data before and after lane replication
    data_t        store_data;
    data_t        lane_data;

    //////////////////////////////////////////////////////////////////////
    // issue order

    // a pop in the same cycle frees the slot
    assign order_push = issue_valid & (~order_full | accepted);

    id_fifo #(
        .payload_t (id_t),
        .DEPTH     (MAX_IDS)
    ) order_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (order_push),
        .data_in  (issue.id),
        .pop      (accepted),
        .data_out (oldest_id),
        .valid    (order_valid),
        .full     (order_full)
    );

    assign empty = ~order_valid;

    // entries written at issue, read by oldest id
    always_ff @(posedge clk) begin
        if (issue_valid)
            entries[issue.id] <= issue;
    end

    assign oldest_entry = entries[oldest_id];

    //////////////////////////////////////////////////////////////////////
    // store forwarding

    // at most one forwarded store outstanding
    assign new_forwarded_store = issue_valid & issue.forwarded_store;

    // held until the store leaves the queue
    always_ff @(posedge clk) begin
        if (rst)
            waiting_r <= 1'b0;
        else
            waiting_r <= new_forwarded_store | (waiting_r & ~fwd_ack);
    end

    always_ff @(posedge clk) begin
        if (new_forwarded_store)
            needed_id_r <= issue.data_id;
    end

    // issue cycle shows data_id directly
    assign fwd_waiting   = new_forwarded_store | waiting_r;
    assign fwd_id_needed = waiting_r ? needed_id_r : issue.data_id;

    // ack when the forwarded store is taken by the master
    assign fwd_ack = accepted & oldest_entry.forwarded_store;

    // writeback still holding fwd_done counts as busy
    assign ready_for_forwarded_store = ~(waiting_r | fwd_done);

    //////////////////////////////////////////////////////////////////////
    // output to bus master

    // forwarded store stalls until its value shows up
    assign transaction_ready = order_valid & (~oldest_entry.forwarded_store | fwd_done);

    assign store_data = oldest_entry.forwarded_store ? fwd_data : oldest_entry.data_in;

    // byte lanes by offset
    // byte 0 lands on its own lane, halfword at offset 2 moves up
    always_comb begin
        case (oldest_entry.addr[1:0])
            2'b01:
                lane_data = {store_data[31:16], store_data[7:0], store_data[7:0]};
            2'b10:
                lane_data = {store_data[15:0], store_data[15:0]};
            2'b11:
                lane_data = {store_data[7:0], store_data[23:0]};
            default:
                lane_data = store_data;
        endcase
    end

    always_comb begin
        transaction.addr    = oldest_entry.addr;
        transaction.load    = oldest_entry.load;
        transaction.store   = oldest_entry.store;
        transaction.fn3     = oldest_entry.fn3;
        transaction.data_in = lane_data;
        transaction.id      = oldest_id;
    end

endmodule

// File: lsu_bus_master.sv
// lsu_bus_master: wishbone classic master, byte selects, load alignment and extension, completion

module lsu_bus_master
    import mem_bus_pkg::*;
    import lsu_pkg::*;
(
    input  logic             clk,
    input  logic             rst,

    // from the queue
    input  logic             transaction_ready,
    input  lsq_transaction_t transaction,
    output logic             accepted,

    // wishbone
    output wb_req_t          wb_req,
    input  wb_rsp_t          wb_rsp,

    // completion
    output logic             done_valid,
    output lsq_done_t        done
);

    typedef enum logic {
        IDLE,
        BUS
    } state_t;

    state_t           state;
    lsq_transaction_t txn_r;
    logic [3:0]       sel;
    data_t            shifted;
    data_t            load_result;
    logic             bus_done;

    //////////////////////////////////////////////////////////////////////
    // control

    // take the oldest op whenever idle
    assign accepted = (state == IDLE) & transaction_ready;
    assign bus_done = (state == BUS) & wb_rsp.ack;

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else if (accepted)
            state <= BUS;
        else if (bus_done)
            state <= IDLE;
    end

    // latched op for the whole bus cycle
    always_ff @(posedge clk) begin
        if (accepted)
            txn_r <= transaction;
    end

    //////////////////////////////////////////////////////////////////////
    // bus request

    // lanes from width and offset
    always_comb begin
        case (txn_r.fn3[1:0])
            SB[1:0]: sel = 4'b0001 << txn_r.addr[1:0];
            SH[1:0]: sel = 4'b0011 << txn_r.addr[1:0];
            default: sel = 4'b1111;
        endcase
    end

    // cyc and stb together until ack
    always_comb begin
        wb_req.cyc = (state == BUS);
        wb_req.stb = (state == BUS);
        wb_req.we  = txn_r.store;
        wb_req.sel = sel;
        wb_req.adr = txn_r.addr[31:2];
        wb_req.dat = txn_r.data_in;
    end

    //////////////////////////////////////////////////////////////////////
    // load data

    // move addressed byte down to bit 0
    assign shifted = wb_rsp.dat >> {txn_r.addr[1:0], 3'b000};

    always_comb begin
        case (txn_r.fn3)
            LB:      load_result = {{24{shifted[7]}}, shifted[7:0]};
            LH:      load_result = {{16{shifted[15]}}, shifted[15:0]};
            LBU:     load_result = {24'b0, shifted[7:0]};
            LHU:     load_result = {16'b0, shifted[15:0]};
            default: load_result = shifted;
        endcase
    end

    // one pulse per op, stores report zero
    always_ff @(posedge clk) begin
        if (rst)
            done_valid <= 1'b0;
        else
            done_valid <= bus_done;
    end

    always_ff @(posedge clk) begin
        if (bus_done) begin
            done.id   <= txn_r.id;
            done.load <= txn_r.load;
            done.data <= txn_r.load ? load_result : '0;
        end
    end

endmodule

// File: lsu_pkg.sv
// load/store unit types: instruction id, issue request, bus transaction and completion structs

package lsu_pkg;

    import mem_bus_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // instruction ids

    // 3 bits, up to 8 operations in flight
    localparam int ID_W = 3;
    typedef logic [ID_W-1:0] id_t;

    //////////////////////////////////////////////////////////////////////
    // issue side

    // one memory op as issued
    // forwarded_store: store data still in flight, comes from data_id later
    typedef struct packed {
        addr_t addr;
        logic  load;
        logic  store;
        fn3_t  fn3;
        data_t data_in;
        id_t   id;
        logic  forwarded_store;
        id_t   data_id;
    } lsq_request_t;

    //////////////////////////////////////////////////////////////////////
    // queue to bus master

    // oldest op, data_in already replicated into byte lanes
    typedef struct packed {
        addr_t addr;
        logic  load;
        logic  store;
        fn3_t  fn3;
        data_t data_in;
        id_t   id;
    } lsq_transaction_t;

    // completion report, data is zero for stores
    typedef struct packed {
        id_t   id;
        logic  load;
        data_t data;
    } lsq_done_t;

endpackage

// File: lsu_top.sv
// lsu_top: load/store queue, wishbone bus master and data ram

module lsu_top
    import mem_bus_pkg::*;
    import lsu_pkg::*;
#(
    parameter int MAX_IDS   = 8,
    parameter int RAM_WORDS = 256
) (
    input  logic         clk,
    input  logic         rst,

    // issue
    input  logic         issue_valid,
    input  lsq_request_t issue,

    // writeback forwarding
    output logic         fwd_waiting,
    output id_t          fwd_id_needed,
    output logic         fwd_ack,
    input  logic         fwd_done,
    input  data_t        fwd_data,
    output logic         ready_for_forwarded_store,

    // status and completion
    output logic         empty,
    output logic         done_valid,
    output lsq_done_t    done
);

    //////////////////////////////////////////////////////////////////////
    // internal links

    // queue to master
    logic             transaction_ready;
    lsq_transaction_t transaction;
    logic             accepted;

    // master to ram
    wb_req_t          wb_req;
    wb_rsp_t          wb_rsp;

    load_store_queue #(
        .MAX_IDS (MAX_IDS)
    ) lsq (
        .clk                       (clk),
        .rst                       (rst),
        .issue_valid               (issue_valid),
        .issue                     (issue),
        .transaction_ready         (transaction_ready),
        .transaction               (transaction),
        .accepted                  (accepted),
        .empty                     (empty),
        .fwd_waiting               (fwd_waiting),
        .fwd_id_needed             (fwd_id_needed),
        .fwd_ack                   (fwd_ack),
        .fwd_done                  (fwd_done),
        .fwd_data                  (fwd_data),
        .ready_for_forwarded_store (ready_for_forwarded_store)
    );

    lsu_bus_master master (
        .clk               (clk),
        .rst               (rst),
        .transaction_ready (transaction_ready),
        .transaction       (transaction),
        .accepted          (accepted),
        .wb_req            (wb_req),
        .wb_rsp            (wb_rsp),
        .done_valid        (done_valid),
        .done              (done)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) ram (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

endmodule

// File: mem_bus_pkg.sv
// memory encodings: address/data types, funct3 codes, wishbone classic request/response structs

package mem_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // basic widths

    // byte address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // riscv funct3 field of a load or store
    typedef logic [2:0] fn3_t;

    //////////////////////////////////////////////////////////////////////
    // funct3 width codes

    // loads, bit 2 set means zero extension
    localparam fn3_t LB  = 3'b000;
    localparam fn3_t LH  = 3'b001;
    localparam fn3_t LW  = 3'b010;
    localparam fn3_t LBU = 3'b100;
    localparam fn3_t LHU = 3'b101;

    // stores share the low bits with the loads
    localparam fn3_t SB  = 3'b000;
    localparam fn3_t SH  = 3'b001;
    localparam fn3_t SW  = 3'b010;

    //////////////////////////////////////////////////////////////////////
    // wishbone classic

    // master side, adr is a word address
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [29:0] adr;
        data_t       dat;
    } wb_req_t;

    // slave side
    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

endpackage

// File: tb_lsu_top.sv
// testbench for lsu_top: clock, reset, lcg stimulus, writeback model, reference memory, checker

module tb_lsu_top
    import mem_bus_pkg::*;
    import lsu_pkg::*;
();

    localparam int          MAX_IDS = 8;
    localparam int          TIMEOUT = 200;
    localparam logic [31:0] SEED    = 32'hb839;

    logic         clk = 1'b0;
    logic         rst;
    logic         issue_valid;
    lsq_request_t issue;
    logic         fwd_waiting;
    id_t          fwd_id_needed;
    logic         fwd_ack;
    logic         fwd_done;
    data_t        fwd_data;
    logic         ready_for_forwarded_store;
    logic         empty;
    logic         done_valid;
    lsq_done_t    done;

    // expected completions in issue order, checker reads by index
    lsq_done_t    exp_q [$];
    int           done_count   = 0;
    int           issued_count = 0;
    id_t          next_id      = '0;

    // reference memory and writeback values per id
    data_t        ref_mem [256];
    data_t        fwd_table [MAX_IDS];
    logic [31:0]  stim_state = SEED;
    logic [31:0]  wb_state   = SEED;

    always #50 clk = ~clk;

    lsu_top uut (
        .clk                       (clk),
        .rst                       (rst),
        .issue_valid               (issue_valid),
        .issue                     (issue),
        .fwd_waiting               (fwd_waiting),
        .fwd_id_needed             (fwd_id_needed),
        .fwd_ack                   (fwd_ack),
        .fwd_done                  (fwd_done),
        .fwd_data                  (fwd_data),
        .ready_for_forwarded_store (ready_for_forwarded_store),
        .empty                     (empty),
        .done_valid                (done_valid),
        .done                      (done)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // test region starts at byte 0x100
    function automatic addr_t make_addr(input logic [3:0] w, input logic [1:0] off);
        return 32'h0000_0100 | {26'b0, w, off};
    endfunction

    // expected load value from a memory word
    function automatic data_t load_ref(input data_t word, input addr_t addr, input fn3_t fn3);
        logic [7:0]  b;
        logic [15:0] h;
        case (addr[1:0])
            2'd0:    b = word[7:0];
            2'd1:    b = word[15:8];
            2'd2:    b = word[23:16];
            default: b = word[31:24];
        endcase
        h = addr[1] ? word[31:16] : word[15:0];
        case (fn3)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'b0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'b0, h};
            default: return word;
        endcase
    endfunction

    // memory word after a store of the given width
    function automatic data_t store_ref(input data_t word, input addr_t addr, input fn3_t fn3,
                                        input data_t data);
        data_t merged;
        merged = word;
        case (fn3[1:0])
            2'b00:   merged[{addr[1:0], 3'b000} +: 8] = data[7:0];
            2'b01:   merged[{addr[1], 4'b0000} +: 16] = data[15:0];
            default: merged = data;
        endcase
        return merged;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // helpers

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("FAILED %s: got %h, expected %h", name, got, expected);
            abort_run();
        end
    endtask

    // upper lcg bits, the low ones repeat quickly
    task automatic draw(output logic [15:0] r);
        stim_state = lcg_next(stim_state);
        r = stim_state[31:16];
    endtask

    task automatic check_idle_outputs();
        check_value("done_valid", 32'(done_valid), 32'd0);
        check_value("fwd_waiting", 32'(fwd_waiting), 32'd0);
        check_value("fwd_ack", 32'(fwd_ack), 32'd0);
        check_value("empty", 32'(empty), 32'd1);
    endtask

    // one issue: waits for a free id, and a free forwarding slot if needed
    task automatic issue_op(input logic is_load, input fn3_t fn3, input addr_t addr,
                            input data_t data, input logic fwd, input id_t data_id);
        lsq_request_t req;
        lsq_done_t    exp;
        int           waited;
        waited = 0;
        forever begin
            @(posedge clk);
            if ((issued_count - done_count < MAX_IDS) &&
                (!fwd || (ready_for_forwarded_store && !fwd_waiting)))
                break;
            issue_valid <= 1'b0;
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout while waiting for room to issue an operation");
                abort_run();
            end
        end
        // forwarded value lives in the writeback table
        if (fwd)
            fwd_table[data_id] = data;
        exp.id   = next_id;
        exp.load = is_load;
        exp.data = is_load ? load_ref(ref_mem[addr[9:2]], addr, fn3) : '0;
        if (!is_load)
            ref_mem[addr[9:2]] = store_ref(ref_mem[addr[9:2]], addr, fn3, data);
        exp_q.push_back(exp);
        req                 = '0;
        req.addr            = addr;
        req.load            = is_load;
        req.store           = ~is_load;
        req.fn3             = fn3;
        // stale data_in on forwarded stores must be ignored
        req.data_in         = fwd ? ~data : data;
        req.id              = next_id;
        req.forwarded_store = fwd;
        req.data_id         = data_id;
        issue_valid <= 1'b1;
        issue       <= req;
        next_id      = next_id + 1'b1;
        issued_count++;
    endtask

    // five loads over one word
    task automatic load_sweep(input logic [3:0] w, input logic [1:0] off);
        issue_op(1'b1, LW, make_addr(w, 2'b00), '0, 1'b0, '0);
        issue_op(1'b1, LB, make_addr(w, off), '0, 1'b0, '0);
        issue_op(1'b1, LBU, make_addr(w, off + 2'd1), '0, 1'b0, '0);
        issue_op(1'b1, LH, make_addr(w, {off[1], 1'b0}), '0, 1'b0, '0);
        issue_op(1'b1, LHU, make_addr(w, {~off[1], 1'b0}), '0, 1'b0, '0);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        issue_valid <= 1'b0;
        while (done_count < exp_q.size()) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout while waiting for outstanding operations to complete");
                abort_run();
            end
        end
        @(negedge clk);
        check_value("empty", 32'(empty), 32'd1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // writeback stage model and completion checker

    initial begin : writeback_model
        int delay;
        int waited;
        fwd_done = 1'b0;
        fwd_data = '0;
        forever begin
            @(posedge clk);
            if (!rst && fwd_waiting && !fwd_done) begin
                wb_state = lcg_next(wb_state);
                delay = int'(wb_state[31:16] % 16'd6);
                repeat (delay) @(posedge clk);
                fwd_done <= 1'b1;
                fwd_data <= fwd_table[fwd_id_needed];
                waited = 0;
                // hold until the store is taken
                forever begin
                    @(posedge clk);
                    if (fwd_ack)
                        break;
                    waited++;
                    if (waited > TIMEOUT) begin
                        $display("timeout while waiting for the forwarded store to be taken");
                        abort_run();
                    end
                end
                fwd_done <= 1'b0;
            end
        end
    end

    initial begin : completion_checker
        lsq_done_t exp;
        forever begin
            @(negedge clk);
            if (!rst && done_valid) begin
                assert (done_count < exp_q.size()) else begin
                    $display("a completion was reported with no operation outstanding");
                    abort_run();
                end
                exp = exp_q[done_count];
                check_value("done.id", 32'(done.id), 32'(exp.id));
                check_value("done.load", 32'(done.load), 32'(exp.load));
                check_value("done.data", done.data, exp.data);
                done_count++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus

    initial begin : stimulus
        logic [15:0] r;
        logic [15:0] d1;
        logic [15:0] d2;
        logic [1:0]  off;
        fn3_t        lfn;
        fn3_t        sfn;
        id_t         fwd_id;
        data_t       fdata;
        logic        acked;
        int          k;
        int          waited;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        for (int i = 0; i < 256; i++)
            ref_mem[i] = '0;
        for (int i = 0; i < MAX_IDS; i++)
            fwd_table[i] = '0;

        // outputs quiet through reset and the cycle after
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        rst <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs();
        end

        // word store then load back
        draw(d1);
        draw(d2);
        issue_op(1'b0, SW, make_addr(4'd1, 2'b00), {d1, d2}, 1'b0, '0);
        issue_op(1'b1, LW, make_addr(4'd1, 2'b00), '0, 1'b0, '0);
        drain();

        // narrow stores at every legal offset
        for (int i = 0; i < 4; i++) begin
            draw(d1);
            draw(d2);
            issue_op(1'b0, SB, make_addr(4'd3, 2'(i)), {d1, d2}, 1'b0, '0);
            load_sweep(4'd3, 2'(i));
        end
        for (int i = 0; i < 4; i += 2) begin
            draw(d1);
            draw(d2);
            issue_op(1'b0, SH, make_addr(4'd3, 2'(i)), {d1, d2}, 1'b0, '0);
            load_sweep(4'd3, 2'(i + 1));
        end
        drain();

        // forwarded halfword store with younger loads behind it
        draw(r);
        fwd_id = r[2:0];
        draw(d1);
        draw(d2);
        fdata = {d1, d2};
        issue_op(1'b0, SH, make_addr(4'd5, 2'b10), fdata, 1'b1, fwd_id);
        @(negedge clk);
        check_value("fwd_waiting", 32'(fwd_waiting), 32'd1);
        check_value("fwd_id_needed", 32'(fwd_id_needed), 32'(fwd_id));
        acked  = 1'b0;
        k      = 0;
        waited = 0;
        while (!acked || k < 2) begin
            if (k == 0)
                issue_op(1'b1, LW, make_addr(4'd5, 2'b00), '0, 1'b0, '0);
            else if (k == 1)
                issue_op(1'b1, LHU, make_addr(4'd5, 2'b10), '0, 1'b0, '0);
            else begin
                @(posedge clk);
                issue_valid <= 1'b0;
            end
            k++;
            @(negedge clk);
            if (fwd_ack)
                acked = 1'b1;
            else if (!acked)
                check_value("ready_for_forwarded_store", 32'(ready_for_forwarded_store), 32'd0);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout while waiting for the forwarded store to be accepted");
                abort_run();
            end
        end
        drain();
        issue_op(1'b1, LW, make_addr(4'd5, 2'b00), '0, 1'b0, '0);
        issue_op(1'b1, LH, make_addr(4'd5, 2'b10), '0, 1'b0, '0);
        drain();

        // random burst
        // r: kind [2:0], width [4:3], offset [6:5], word [10:7], data_id [13:11]
        for (int n = 0; n < 300; n++) begin
            draw(r);
            draw(d1);
            draw(d2);
            case (r[4:3])
                2'b00: begin
                    off = r[6:5];
                    lfn = r[14] ? LBU : LB;
                    sfn = SB;
                end
                2'b01: begin
                    off = {r[6], 1'b0};
                    lfn = r[14] ? LHU : LH;
                    sfn = SH;
                end
                default: begin
                    off = 2'b00;
                    lfn = LW;
                    sfn = SW;
                end
            endcase
            if (r[2:0] < 3'd4)
                issue_op(1'b1, lfn, make_addr(r[10:7], off), '0, 1'b0, '0);
            else
                issue_op(1'b0, sfn, make_addr(r[10:7], off), {d1, d2}, r[2:0] == 3'd7,
                         r[13:11]);
        end
        drain();

        $display("NO ERRORS");
        $finish;
    end

endmodule
